//--- bench/dcache_mem_sva.sv
/*
 * L1 data cache memory checker
 * Bound to the cache memory top level. Keeps a shadow copy of the tags,
 * valid bits and words written through the top ports, and checks the
 * arbitration rules and the read results against it.
 */

`timescale 1ns/1ns

`include "dcache_consts.svh"

module dcache_mem_sva (
  input logic                                                 clk_i,
  input logic                                                 rst_ni,
  input dcache_addr_pkg::port_mask_t                          rd_req_i,
  input dcache_addr_pkg::port_mask_t                          rd_prio_i,
  input dcache_addr_pkg::port_mask_t                          rd_tag_only_i,
  input dcache_addr_pkg::set_idx_t  [`DCACHE_NUM_PORTS-1:0]   rd_idx_i,
  input dcache_addr_pkg::bank_sel_t [`DCACHE_NUM_PORTS-1:0]   rd_off_i,
  input dcache_addr_pkg::tag_t      [`DCACHE_NUM_PORTS-1:0]   rd_tag_i,
  input dcache_addr_pkg::port_mask_t                          rd_ack_o,
  input dcache_addr_pkg::way_mask_t                           rd_vld_bits_o,
  input dcache_addr_pkg::way_mask_t                           rd_hit_oh_o,
  input dcache_data_pkg::word_t                               rd_data_o,
  input logic                                                 wr_cl_vld_i,
  input dcache_addr_pkg::way_mask_t                           wr_cl_we_i,
  input dcache_addr_pkg::tag_t                                wr_cl_tag_i,
  input dcache_addr_pkg::set_idx_t                            wr_cl_idx_i,
  input dcache_data_pkg::line_t                               wr_cl_data_i,
  input dcache_addr_pkg::way_mask_t                           wr_vld_bits_i,
  input dcache_addr_pkg::way_mask_t                           wr_req_i,
  input dcache_addr_pkg::set_idx_t                            wr_idx_i,
  input dcache_addr_pkg::bank_sel_t                           wr_off_i,
  input dcache_data_pkg::word_t                               wr_data_i,
  input logic                                                 wr_ack_o
);

  import dcache_addr_pkg::*;
  import dcache_data_pkg::*;

  int        err_cnt = 0;
  tag_t      tag_q  [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];
  logic      vld_q  [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];
  word_t     word_q [`DCACHE_NUM_SETS][`DCACHE_NUM_BANKS][`DCACHE_NUM_WAYS];
  int        wait_cnt [`DCACHE_NUM_PORTS];
  logic      ack_q, tonly_q;
  port_idx_t port_q, gnt_port;
  set_idx_t  idx_q;
  bank_sel_t off_q;
  way_mask_t exp_vld, exp_hit;
  word_t     exp_data;
  logic      exp_wr_ack, rr_ok, hi_pend;

  assign hi_pend = |(rd_req_i & rd_prio_i);

  // shadow copy and the registered lookup
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < `DCACHE_NUM_SETS; s++) begin
        for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
          tag_q[s][w] <= '0;
          vld_q[s][w] <= 1'b0;
          for (int k = 0; k < `DCACHE_NUM_BANKS; k++) begin
            word_q[s][k][w] <= '0;
          end
        end
      end
      ack_q   <= 1'b0;
      tonly_q <= 1'b0;
      port_q  <= '0;
      idx_q   <= '0;
      off_q   <= '0;
    end else begin
      for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
        if (wr_cl_vld_i && wr_cl_we_i[w]) begin
          tag_q[wr_cl_idx_i][w] <= wr_cl_tag_i;
          vld_q[wr_cl_idx_i][w] <= wr_vld_bits_i[w];
          for (int k = 0; k < `DCACHE_NUM_BANKS; k++) begin
            word_q[wr_cl_idx_i][k][w] <= wr_cl_data_i[k*`DCACHE_WORD_WIDTH +: `DCACHE_WORD_WIDTH];
          end
        end
        if (wr_ack_o && wr_req_i[w]) begin
          word_q[wr_idx_i][wr_off_i][w] <= wr_data_i;
        end
      end
      ack_q   <= |rd_ack_o;
      tonly_q <= rd_tag_only_i[gnt_port];
      port_q  <= gnt_port;
      idx_q   <= rd_idx_i[gnt_port];
      off_q   <= rd_off_i[gnt_port];
    end
  end

  // grants that pass over a waiting port of the same priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int p = 0; p < `DCACHE_NUM_PORTS; p++) begin
        wait_cnt[p] <= 0;
      end
    end else begin
      for (int p = 0; p < `DCACHE_NUM_PORTS; p++) begin
        if (!rd_req_i[p] || rd_ack_o[p] || (hi_pend && !rd_prio_i[p])) begin
          wait_cnt[p] <= 0;
        end else if (|rd_ack_o) begin
          wait_cnt[p] <= wait_cnt[p] + 1;
        end
      end
    end
  end

  always_comb begin
    gnt_port = '0;
    rr_ok    = 1'b1;
    exp_data = '0;
    for (int p = 0; p < `DCACHE_NUM_PORTS; p++) begin
      if (rd_ack_o[p]) begin
        gnt_port = port_idx_t'(p);
      end
      if (wait_cnt[p] >= `DCACHE_NUM_PORTS) begin
        rr_ok = 1'b0;
      end
    end
    for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
      exp_vld[w] = vld_q[idx_q][w];
      exp_hit[w] = vld_q[idx_q][w] && (tag_q[idx_q][w] == rd_tag_i[port_q]);
      if (exp_hit[w]) begin
        exp_data = word_q[idx_q][off_q][w];
      end
    end
    // tag-only reads leave the banks free
    exp_wr_ack = (|wr_req_i) && !wr_cl_vld_i
               && !((|rd_ack_o) && !rd_tag_only_i[gnt_port] && (rd_off_i[gnt_port] == wr_off_i));
  end

  ////////////////////
  // arbitration
  ////////////////////

  a_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(rd_ack_o))
    else begin err_cnt++; $error("more than one read ack"); end
  a_cl_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_cl_vld_i |-> (rd_ack_o == '0) && !wr_ack_o)
    else begin err_cnt++; $error("ack during cacheline write"); end
  a_prio: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hi_pend |-> ((rd_ack_o & ~rd_prio_i) == '0))
    else begin err_cnt++; $error("low priority port acked"); end
  a_rr: assert property (@(posedge clk_i) disable iff (!rst_ni) rr_ok)
    else begin err_cnt++; $error("round robin starved a port"); end
  a_wr_ack: assert property (@(posedge clk_i) disable iff (!rst_ni) wr_ack_o == exp_wr_ack)
    else begin err_cnt++; $error("word write ack wrong"); end

  ////////////////////
  // read results
  ////////////////////

  a_hit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_hit_oh_o) && (rd_hit_oh_o == (ack_q ? exp_hit : '0)))
    else begin err_cnt++; $error("hit vector wrong"); end
  a_vld: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_q |-> rd_vld_bits_o == exp_vld)
    else begin err_cnt++; $error("valid bits wrong"); end
  a_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ack_q && !tonly_q && (|exp_hit)) |-> rd_data_o == exp_data)
    else begin err_cnt++; $error("read data wrong"); end

endmodule

bind dcache_mem dcache_mem_sva u_sva (.*);

//--- bench/dcache_mem_tb.sv
/*
 * L1 data cache memory testbench
 * Fills the arrays with cacheline writes, then runs random reads, port
 * contention bursts, back-to-back read streams and word writes.
 * The bound checker does the checking.
 */

`timescale 1ns/1ns

`include "dcache_consts.svh"

module dcache_mem_tb;

  import dcache_addr_pkg::*;
  import dcache_data_pkg::*;

  localparam int unsigned MaxCycles = 2000;

  logic                                 clk_i = 1'b0;
  logic                                 rst_ni = 1'b0;
  port_mask_t                           rd_req, rd_prio, rd_tag_only, rd_ack;
  set_idx_t   [`DCACHE_NUM_PORTS-1:0]   rd_idx;
  bank_sel_t  [`DCACHE_NUM_PORTS-1:0]   rd_off;
  tag_t       [`DCACHE_NUM_PORTS-1:0]   rd_tag;
  way_mask_t                            rd_vld_bits, rd_hit_oh;
  word_t                                rd_data, wr_data;
  logic                                 wr_cl_vld, wr_ack;
  way_mask_t                            wr_cl_we, wr_vld_bits, wr_req;
  tag_t                                 wr_cl_tag;
  set_idx_t                             wr_cl_idx, wr_idx;
  line_t                                wr_cl_data;
  bank_sel_t                            wr_off;

  int   seed = 32'h41d7_341c;
  int   cycle_cnt = 0;
  tag_t tag_tbl [`DCACHE_NUM_SETS][`DCACHE_NUM_WAYS];

  dcache_mem u_dut (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .rd_req_i (rd_req), .rd_prio_i (rd_prio), .rd_tag_only_i (rd_tag_only),
    .rd_idx_i (rd_idx), .rd_off_i (rd_off), .rd_tag_i (rd_tag), .rd_ack_o (rd_ack),
    .rd_vld_bits_o (rd_vld_bits), .rd_hit_oh_o (rd_hit_oh), .rd_data_o (rd_data),
    .wr_cl_vld_i (wr_cl_vld), .wr_cl_we_i (wr_cl_we), .wr_cl_tag_i (wr_cl_tag),
    .wr_cl_idx_i (wr_cl_idx), .wr_cl_data_i (wr_cl_data), .wr_vld_bits_i (wr_vld_bits),
    .wr_req_i (wr_req), .wr_idx_i (wr_idx), .wr_off_i (wr_off), .wr_data_i (wr_data),
    .wr_ack_o (wr_ack)
  );

  always #20 clk_i = ~clk_i;

  // run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  always @(negedge clk_i) begin
    if (u_dut.u_sva.err_cnt != 0) begin
      $display("ERROR at %0t ns: assertion failure in the checker", $time);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  // refill fields for way w of set s, applied once wr_cl_vld goes high
  task automatic prepare_line(input set_idx_t s, input int w, input logic vld);
    wr_cl_we    = way_mask_t'(1 << w);
    wr_vld_bits = {`DCACHE_NUM_WAYS{vld}};
    wr_cl_idx   = s;
    // way number in the top bits keeps tags unique per set
    wr_cl_tag   = {2'(w), 6'($random(seed))};
    for (int k = 0; k < `DCACHE_NUM_BANKS; k++) begin
      wr_cl_data[k*`DCACHE_WORD_WIDTH +: `DCACHE_WORD_WIDTH] = $random(seed);
    end
    tag_tbl[s][w] = wr_cl_tag;
  endtask

  task automatic write_line(input set_idx_t s, input int w, input logic vld);
    @(negedge clk_i);
    prepare_line(s, w, vld);
    wr_cl_vld = 1'b1;
    @(negedge clk_i);
    wr_cl_vld = 1'b0;
  endtask

  // sets up port p for a read, mostly with a stored tag
  task automatic pick_read(input int p);
    int w;
    rd_idx[p]      = set_idx_t'($random(seed));
    rd_off[p]      = bank_sel_t'($random(seed));
    rd_tag_only[p] = ($random(seed) & 3) == 0;
    rd_prio[p]     = 1'($random(seed));
    w = $random(seed) & 3;
    rd_tag[p] = (($random(seed) & 3) != 0) ? tag_tbl[rd_idx[p]][w] : tag_t'($random(seed));
  endtask

  // holds the requests until each one is acked
  // for the first hold cycles an acked port asks again right away
  // with_line starts a prepared refill in the first cycle
  task automatic run_ops(input port_mask_t ports, input way_mask_t wr_ways,
                         input logic with_line, input int unsigned hold);
    port_mask_t  acked;
    logic        wr_done;
    int unsigned cyc;
    cyc = 0;
    @(negedge clk_i);
    rd_req    = ports;
    wr_req    = wr_ways;
    wr_cl_vld = with_line;
    while (rd_req != '0 || wr_req != '0) begin
      #1;
      acked   = rd_ack;
      wr_done = wr_ack;
      @(negedge clk_i);
      wr_cl_vld = 1'b0;
      cyc++;
      if (cyc >= hold) begin
        rd_req = rd_req & ~acked;
      end
      if (wr_done) begin
        wr_req = '0;
      end
    end
    @(negedge clk_i);
  endtask

  initial begin
    int w;
    rd_req = '0;
    rd_prio = '0;
    rd_tag_only = '0;
    rd_idx = '0;
    rd_off = '0;
    rd_tag = '0;
    wr_cl_vld = 1'b0;
    wr_cl_we = '0;
    wr_cl_tag = '0;
    wr_cl_idx = '0;
    wr_cl_data = '0;
    wr_vld_bits = '0;
    wr_req = '0;
    wr_idx = '0;
    wr_off = '0;
    wr_data = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int s = 0; s < `DCACHE_NUM_SETS; s++) begin
      for (int v = 0; v < `DCACHE_NUM_WAYS; v++) begin
        write_line(set_idx_t'(s), v, 1'b1);
      end
    end

    for (int n = 0; n < 150; n++) begin
      pick_read(n % `DCACHE_NUM_PORTS);
      run_ops(port_mask_t'(1 << (n % `DCACHE_NUM_PORTS)), '0, 1'b0, 0);
    end

    // contention between all ports
    for (int n = 0; n < 20; n++) begin
      for (int p = 0; p < `DCACHE_NUM_PORTS; p++) begin
        pick_read(p);
      end
      run_ops('1, '0, 1'b0, 0);
    end

    // back-to-back reads, every priority grouping of the ports
    for (int n = 0; n < 8; n++) begin
      for (int p = 0; p < `DCACHE_NUM_PORTS; p++) begin
        pick_read(p);
      end
      rd_prio = port_mask_t'(n);
      run_ops('1, '0, 1'b0, 20);
    end

    // word write next to a read, then read the word back
    for (int n = 0; n < 60; n++) begin
      pick_read(0);
      rd_prio[0] = 1'b0;
      wr_idx  = set_idx_t'($random(seed));
      wr_off  = (n % 2 == 0) ? rd_off[0] : bank_sel_t'($random(seed));
      wr_data = $random(seed);
      w = $random(seed) & 3;
      run_ops(3'b001, way_mask_t'(1 << w), 1'b0, 0);
      rd_idx[0] = wr_idx;
      rd_off[0] = wr_off;
      rd_tag[0] = tag_tbl[wr_idx][w];
      rd_tag_only[0] = 1'b0;
      run_ops(3'b001, '0, 1'b0, 0);
    end

    // invalidated ways must miss
    for (int n = 0; n < 8; n++) begin
      // refill arrives together with a read and a word write
      prepare_line(set_idx_t'(n), n % `DCACHE_NUM_WAYS, 1'b0);
      pick_read(2);
      wr_idx  = set_idx_t'(n);
      wr_off  = bank_sel_t'(n);
      wr_data = $random(seed);
      run_ops(3'b100, way_mask_t'(1 << (n % `DCACHE_NUM_WAYS)), 1'b1, 0);
      rd_idx[1] = set_idx_t'(n);
      rd_tag[1] = tag_tbl[n][n % `DCACHE_NUM_WAYS];
      rd_off[1] = bank_sel_t'(n);
      rd_tag_only[1] = 1'b0;
      run_ops(3'b010, '0, 1'b0, 0);
    end

    repeat (2) @(negedge clk_i);
    if (u_dut.u_sva.err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the cache memory testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module dcache_mem_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vdcache_mem_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
fi

if grep -q "^TEST PASSED$" sim.log; then
  exit 0
fi
exit 1

//--- sim.f
+incdir+source
source/dcache_addr_pkg.sv
source/dcache_data_pkg.sv
source/dcache_bank_arbiter.sv
source/dcache_sram.sv
source/dcache_hit_select.sv
source/dcache_mem.sv
bench/dcache_mem_sva.sv
bench/dcache_mem_tb.sv

//--- source/dcache_addr_pkg.sv
/*
 * L1 data cache address types
 * Fields that select a location in the arrays: tag, set index,
 * bank select, plus the way and read-port vectors.
 */

`include "dcache_consts.svh"

package dcache_addr_pkg;

  //////////////////////
  // address fields
  //////////////////////

  typedef logic [`DCACHE_TAG_WIDTH-1:0] tag_t;

  typedef logic [$clog2(`DCACHE_NUM_SETS)-1:0] set_idx_t;

  // word offset in a line, equal to the bank number
  typedef logic [$clog2(`DCACHE_NUM_BANKS)-1:0] bank_sel_t;

  //////////////////////
  // selectors
  //////////////////////

  typedef logic [$clog2(`DCACHE_NUM_PORTS)-1:0] port_idx_t;

  // one bit per way
  typedef logic [`DCACHE_NUM_WAYS-1:0] way_mask_t;

  // one bit per read port
  typedef logic [`DCACHE_NUM_PORTS-1:0] port_mask_t;

endpackage

//--- source/dcache_bank_arbiter.sv
/*
 * L1 data cache bank arbiter
 * First pipeline stage. Masks low-priority reads when a high-priority read
 * is pending, picks one read round-robin and routes it, the cacheline write
 * or the word write onto the tag array and the data banks.
 */

`timescale 1ns/1ns

`include "dcache_consts.svh"

module dcache_bank_arbiter (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  // read ports
  input  dcache_addr_pkg::port_mask_t                          rd_req_i,
  input  dcache_addr_pkg::port_mask_t                          rd_prio_i,
  input  dcache_addr_pkg::port_mask_t                          rd_tag_only_i,
  input  dcache_addr_pkg::set_idx_t  [`DCACHE_NUM_PORTS-1:0]   rd_idx_i,
  input  dcache_addr_pkg::bank_sel_t [`DCACHE_NUM_PORTS-1:0]   rd_off_i,
  output dcache_addr_pkg::port_mask_t                          rd_ack_o,
  // cacheline write
  input  logic                                                 wr_cl_vld_i,
  input  dcache_addr_pkg::way_mask_t                           wr_cl_we_i,
  input  dcache_addr_pkg::set_idx_t                            wr_cl_idx_i,
  // word write
  input  dcache_addr_pkg::way_mask_t                           wr_req_i,
  input  dcache_addr_pkg::set_idx_t                            wr_idx_i,
  input  dcache_addr_pkg::bank_sel_t                           wr_off_i,
  output logic                                                 wr_ack_o,
  // tag array
  output dcache_addr_pkg::way_mask_t                           tag_req_o,
  output logic                                                 tag_we_o,
  output dcache_addr_pkg::set_idx_t                            tag_idx_o,
  // data banks
  output logic                       [`DCACHE_NUM_BANKS-1:0]   bank_req_o,
  output logic                       [`DCACHE_NUM_BANKS-1:0]   bank_we_o,
  output dcache_addr_pkg::set_idx_t  [`DCACHE_NUM_BANKS-1:0]   bank_idx_o,
  output dcache_addr_pkg::way_mask_t [`DCACHE_NUM_BANKS-1:0]   bank_way_we_o,
  // to hit select
  output logic                                                 lookup_en_o,
  output dcache_addr_pkg::port_idx_t                           sel_port_o,
  output dcache_addr_pkg::bank_sel_t                           sel_off_o
);

  import dcache_addr_pkg::*;

  port_mask_t rd_req_prio;
  port_mask_t rd_req_masked;
  port_idx_t  rr_q, rr_d;
  port_idx_t  sel_port;
  bank_sel_t  sel_off;
  logic       rd_any;
  logic       rd_gnt;
  logic       rd_data_req;
  logic       wr_collision;

  //////////////////////
  // read arbitration
  //////////////////////

  // any high-priority request hides all low-priority ones
  assign rd_req_prio   = rd_req_i & rd_prio_i;
  assign rd_req_masked = (|rd_req_prio) ? rd_req_prio : rd_req_i;

  // first requester at or after the pointer wins
  always_comb begin : p_rr_pick
    int unsigned idx;
    sel_port = rr_q;
    rd_any   = 1'b0;
    for (int unsigned i = 0; i < `DCACHE_NUM_PORTS; i++) begin
      idx = (rr_q + i) % `DCACHE_NUM_PORTS;
      if (!rd_any && rd_req_masked[idx]) begin
        rd_any   = 1'b1;
        sel_port = port_idx_t'(idx);
      end
    end
  end

  // a refill stalls every read
  assign rd_gnt = rd_any & ~wr_cl_vld_i;

  always_comb begin
    rd_ack_o = '0;
    if (rd_gnt) begin
      rd_ack_o[sel_port] = 1'b1;
    end
  end

  // pointer moves past the winner, and only on a grant
  assign rr_d = (sel_port == port_idx_t'(`DCACHE_NUM_PORTS - 1)) ? '0 : sel_port + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (rd_gnt) begin
      rr_q <= rr_d;
    end
  end

  assign sel_off     = rd_off_i[sel_port];
  assign lookup_en_o = rd_gnt;
  assign sel_port_o  = sel_port;
  assign sel_off_o   = sel_off;

  //////////////////////
  // tag array
  //////////////////////

  // reads look up all ways, refills write the selected ones
  assign tag_req_o = wr_cl_vld_i ? wr_cl_we_i : {`DCACHE_NUM_WAYS{rd_gnt}};
  assign tag_we_o  = wr_cl_vld_i;
  assign tag_idx_o = wr_cl_vld_i ? wr_cl_idx_i : rd_idx_i[sel_port];

  //////////////////////
  // data banks
  //////////////////////

  assign rd_data_req  = rd_gnt & ~rd_tag_only_i[sel_port];
  assign wr_collision = rd_data_req & (sel_off == wr_off_i);
  assign wr_ack_o     = (|wr_req_i) & ~wr_cl_vld_i & ~wr_collision;

  always_comb begin : p_bank_req
    bank_req_o    = '0;
    bank_we_o     = '0;
    bank_idx_o    = '0;
    bank_way_we_o = '0;
    if (wr_cl_vld_i) begin
      // refill writes every bank of the selected ways
      bank_req_o = '1;
      bank_we_o  = '1;
      for (int k = 0; k < `DCACHE_NUM_BANKS; k++) begin
        bank_idx_o[k]    = wr_cl_idx_i;
        bank_way_we_o[k] = wr_cl_we_i;
      end
    end else begin
      if (rd_data_req) begin
        bank_req_o[sel_off] = 1'b1;
        bank_idx_o[sel_off] = rd_idx_i[sel_port];
      end
      // word write shares the cycle when it targets another bank
      if (wr_ack_o) begin
        bank_req_o[wr_off_i]    = 1'b1;
        bank_we_o[wr_off_i]     = 1'b1;
        bank_idx_o[wr_off_i]    = wr_idx_i;
        bank_way_we_o[wr_off_i] = wr_req_i;
      end
    end
  end

endmodule

//--- source/dcache_consts.svh
/*
 * L1 data cache memory constants
 * Geometry of the tag and data arrays, the word and tag widths and the
 * number of read ports that compete for the arrays.
 */

`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// set associativity
`define DCACHE_NUM_WAYS 4

// one data bank per word offset in a line
`define DCACHE_NUM_BANKS 4

// rows in every array
`define DCACHE_NUM_SETS 16

// stored tag, valid bit not included
`define DCACHE_TAG_WIDTH 8

`define DCACHE_WORD_WIDTH 32

// read ports into the arbiter
`define DCACHE_NUM_PORTS 3

`endif

//--- source/dcache_data_pkg.sv
/*
 * L1 data cache content types
 * What the arrays hold: data words, tag entries with their valid bit,
 * and a full cacheline as delivered by a refill.
 */

`include "dcache_consts.svh"

package dcache_data_pkg;

  //////////////////////
  // stored content
  //////////////////////

  typedef logic [`DCACHE_WORD_WIDTH-1:0] word_t;

  // valid bit on top, tag below
  typedef logic [`DCACHE_TAG_WIDTH:0] tag_entry_t;

  // word k of the line sits at bits k*WORD_WIDTH and up
  typedef logic [`DCACHE_NUM_BANKS*`DCACHE_WORD_WIDTH-1:0] line_t;

  //////////////////////
  // entry fields
  //////////////////////

  // index of the valid bit inside a tag entry
  localparam int unsigned TagEntryVldBit = `DCACHE_TAG_WIDTH;

endpackage

//--- source/dcache_hit_select.sv
/*
 * L1 data cache hit select
 * Second pipeline stage. Takes the late tag of the granted port, compares
 * it against every valid way and returns the word of the hitting way.
 */

`timescale 1ns/1ns

`include "dcache_consts.svh"

module dcache_hit_select (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 lookup_en_i,
  input  dcache_addr_pkg::port_idx_t                           sel_port_i,
  input  dcache_addr_pkg::bank_sel_t                           sel_off_i,
  // tags arrive one cycle after the grant
  input  dcache_addr_pkg::tag_t      [`DCACHE_NUM_PORTS-1:0]   rd_tag_i,
  input  dcache_data_pkg::tag_entry_t [`DCACHE_NUM_WAYS-1:0]   tag_rdata_i,
  input  dcache_data_pkg::word_t
         [`DCACHE_NUM_BANKS-1:0][`DCACHE_NUM_WAYS-1:0]         bank_rdata_i,
  output dcache_addr_pkg::way_mask_t                           rd_vld_bits_o,
  output dcache_addr_pkg::way_mask_t                           rd_hit_oh_o,
  output dcache_data_pkg::word_t                               rd_data_o
);

  import dcache_addr_pkg::*;
  import dcache_data_pkg::*;

  logic      lookup_en_q;
  port_idx_t sel_port_q;
  bank_sel_t sel_off_q;
  tag_t      cmp_tag;
  way_mask_t vld_bits;
  way_mask_t hit_oh;
  word_t     hit_word;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lookup_en_q <= 1'b0;
      sel_port_q  <= '0;
      sel_off_q   <= '0;
    end else begin
      lookup_en_q <= lookup_en_i;
      sel_port_q  <= sel_port_i;
      sel_off_q   <= sel_off_i;
    end
  end

  //////////////////////
  // tag compare
  //////////////////////

  assign cmp_tag = rd_tag_i[sel_port_q];

  // the stored tags are unique per set, so at most one way matches
  for (genvar w = 0; w < `DCACHE_NUM_WAYS; w++) begin : gen_cmp
    assign vld_bits[w] = tag_rdata_i[w][TagEntryVldBit];
    assign hit_oh[w]   = lookup_en_q & vld_bits[w]
                       & (tag_rdata_i[w][`DCACHE_TAG_WIDTH-1:0] == cmp_tag);
  end

  //////////////////////
  // word select
  //////////////////////

  // and-or mux over the registered bank, zero on a miss
  always_comb begin : p_word_sel
    hit_word = '0;
    for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
      hit_word = hit_word | (bank_rdata_i[sel_off_q][w] & {`DCACHE_WORD_WIDTH{hit_oh[w]}});
    end
  end

  assign rd_vld_bits_o = vld_bits;
  assign rd_hit_oh_o   = hit_oh;
  assign rd_data_o     = hit_word;

endmodule

//--- source/dcache_mem.sv
/*
 * L1 data cache memory block
 * Write-through cache arrays: set-associative tag/valid array, one data
 * bank per word offset, an arbiter for the read ports and the hit select
 * stage that returns valid bits, hit vector and word one cycle after ack.
 */

`timescale 1ns/1ns

`include "dcache_consts.svh"

module dcache_mem (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  // read ports
  input  dcache_addr_pkg::port_mask_t                          rd_req_i,
  input  dcache_addr_pkg::port_mask_t                          rd_prio_i,
  input  dcache_addr_pkg::port_mask_t                          rd_tag_only_i,
  input  dcache_addr_pkg::set_idx_t  [`DCACHE_NUM_PORTS-1:0]   rd_idx_i,
  input  dcache_addr_pkg::bank_sel_t [`DCACHE_NUM_PORTS-1:0]   rd_off_i,
  input  dcache_addr_pkg::tag_t      [`DCACHE_NUM_PORTS-1:0]   rd_tag_i,
  output dcache_addr_pkg::port_mask_t                          rd_ack_o,
  output dcache_addr_pkg::way_mask_t                           rd_vld_bits_o,
  output dcache_addr_pkg::way_mask_t                           rd_hit_oh_o,
  output dcache_data_pkg::word_t                               rd_data_o,
  // cacheline write
  input  logic                                                 wr_cl_vld_i,
  input  dcache_addr_pkg::way_mask_t                           wr_cl_we_i,
  input  dcache_addr_pkg::tag_t                                wr_cl_tag_i,
  input  dcache_addr_pkg::set_idx_t                            wr_cl_idx_i,
  input  dcache_data_pkg::line_t                               wr_cl_data_i,
  input  dcache_addr_pkg::way_mask_t                           wr_vld_bits_i,
  // word write
  input  dcache_addr_pkg::way_mask_t                           wr_req_i,
  input  dcache_addr_pkg::set_idx_t                            wr_idx_i,
  input  dcache_addr_pkg::bank_sel_t                           wr_off_i,
  input  dcache_data_pkg::word_t                               wr_data_i,
  output logic                                                 wr_ack_o
);

  import dcache_addr_pkg::*;
  import dcache_data_pkg::*;

  way_mask_t                          tag_req;
  logic                               tag_we;
  set_idx_t                           tag_idx;
  tag_entry_t [`DCACHE_NUM_WAYS-1:0]  tag_wdata;
  tag_entry_t [`DCACHE_NUM_WAYS-1:0]  tag_rdata;

  logic      [`DCACHE_NUM_BANKS-1:0]                         bank_req;
  logic      [`DCACHE_NUM_BANKS-1:0]                         bank_we;
  set_idx_t  [`DCACHE_NUM_BANKS-1:0]                         bank_idx;
  way_mask_t [`DCACHE_NUM_BANKS-1:0]                         bank_way_we;
  word_t     [`DCACHE_NUM_BANKS-1:0][`DCACHE_NUM_WAYS-1:0]   bank_wdata;
  word_t     [`DCACHE_NUM_BANKS-1:0][`DCACHE_NUM_WAYS-1:0]   bank_rdata;

  logic      lookup_en;
  port_idx_t sel_port;
  bank_sel_t sel_off;

  //////////////////////
  // arbitration
  //////////////////////

  dcache_bank_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_prio_i     (rd_prio_i),
    .rd_tag_only_i (rd_tag_only_i),
    .rd_idx_i      (rd_idx_i),
    .rd_off_i      (rd_off_i),
    .rd_ack_o      (rd_ack_o),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .wr_cl_we_i    (wr_cl_we_i),
    .wr_cl_idx_i   (wr_cl_idx_i),
    .wr_req_i      (wr_req_i),
    .wr_idx_i      (wr_idx_i),
    .wr_off_i      (wr_off_i),
    .wr_ack_o      (wr_ack_o),
    .tag_req_o     (tag_req),
    .tag_we_o      (tag_we),
    .tag_idx_o     (tag_idx),
    .bank_req_o    (bank_req),
    .bank_we_o     (bank_we),
    .bank_idx_o    (bank_idx),
    .bank_way_we_o (bank_way_we),
    .lookup_en_o   (lookup_en),
    .sel_port_o    (sel_port),
    .sel_off_o     (sel_off)
  );

  //////////////////////
  // tag array
  //////////////////////

  // valid bit packed above the tag
  for (genvar w = 0; w < `DCACHE_NUM_WAYS; w++) begin : gen_tag_wdata
    assign tag_wdata[w] = {wr_vld_bits_i[w], wr_cl_tag_i};
  end

  dcache_sram #(
    .lane_t   (tag_entry_t),
    .NumWords (`DCACHE_NUM_SETS)
  ) u_tag_sram (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (|tag_req),
    .we_i     (tag_we),
    .way_we_i (tag_req),
    .addr_i   (tag_idx),
    .wdata_i  (tag_wdata),
    .rdata_o  (tag_rdata)
  );

  //////////////////////
  // data banks
  //////////////////////

  for (genvar k = 0; k < `DCACHE_NUM_BANKS; k++) begin : gen_bank
    // refill takes word k of the line, otherwise the single word
    for (genvar w = 0; w < `DCACHE_NUM_WAYS; w++) begin : gen_way
      assign bank_wdata[k][w] = wr_cl_vld_i ?
                                wr_cl_data_i[k*`DCACHE_WORD_WIDTH +: `DCACHE_WORD_WIDTH] :
                                wr_data_i;
    end

    dcache_sram #(
      .lane_t   (word_t),
      .NumWords (`DCACHE_NUM_SETS)
    ) u_data_sram (
      .clk_i    (clk_i),
      .rst_ni   (rst_ni),
      .req_i    (bank_req[k]),
      .we_i     (bank_we[k]),
      .way_we_i (bank_way_we[k]),
      .addr_i   (bank_idx[k]),
      .wdata_i  (bank_wdata[k]),
      .rdata_o  (bank_rdata[k])
    );
  end

  //////////////////////
  // hit select
  //////////////////////

  dcache_hit_select u_hit_select (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_en_i   (lookup_en),
    .sel_port_i    (sel_port),
    .sel_off_i     (sel_off),
    .rd_tag_i      (rd_tag_i),
    .tag_rdata_i   (tag_rdata),
    .bank_rdata_i  (bank_rdata),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

//--- source/dcache_sram.sv
/*
 * L1 data cache storage array
 * Single-port synchronous array with one lane per way. A read returns
 * all lanes of a row one cycle later, a write updates the masked lanes.
 */

`timescale 1ns/1ns

`include "dcache_consts.svh"

module dcache_sram #(
  parameter type         lane_t   = logic,
  parameter int unsigned NumWords = 16
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  req_i,
  input  logic                                  we_i,
  input  dcache_addr_pkg::way_mask_t            way_we_i,
  input  logic [$clog2(NumWords)-1:0]           addr_i,
  input  lane_t [`DCACHE_NUM_WAYS-1:0]          wdata_i,
  output lane_t [`DCACHE_NUM_WAYS-1:0]          rdata_o
);

  lane_t [`DCACHE_NUM_WAYS-1:0] mem_q [NumWords];
  lane_t [`DCACHE_NUM_WAYS-1:0] rdata_q;

  // cleared on reset so every valid bit starts low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumWords; i++) begin
        mem_q[i] <= '0;
      end
      rdata_q <= '0;
    end else if (req_i) begin
      if (we_i) begin
        for (int w = 0; w < `DCACHE_NUM_WAYS; w++) begin
          if (way_we_i[w]) begin
            mem_q[addr_i][w] <= wdata_i[w];
          end
        end
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule
